// File: common/cache_pkg.sv
package cache_pkg;

  // Cache geometry
  localparam int WAYS        = 4;
  localparam int SETS        = 16;

  // Address fields of a 32-bit byte address
  localparam int SET_BITS    = 4;
  localparam int OFFSET_BITS = 5;
  localparam int TAG_BITS    = 23;

  // Line and memory beat sizes
  localparam int LINE_BITS   = 256;
  localparam int BEAT_BITS   = 64;
  localparam int BEATS       = 4;

  // Controller states
  typedef enum logic [2:0] {
    IDLE,       // Waiting for a CPU request or a back-invalidate
    LOOKUP,     // Tag compare, respond on hit or pick miss path
    WRITEBACK,  // Dirty victim line going out to memory
    REFILL,     // Missing line coming in from memory
    INSTALL,    // Refilled line written into the victim way
    INVAL       // Back-invalidate read and handshake with outer level
  } dcache_state_e;

  // Burst direction on the memory port
  typedef enum logic {
    BURST_READ,
    BURST_WRITE
  } burst_op_e;

  // One beat on the memory port
  typedef struct packed {
    logic [31:0]          addr;
    logic                 write;
    logic [BEAT_BITS-1:0] wdata;
  } dfp_beat_t;

  // Lookup result handed to the controller
  typedef struct packed {
    logic [WAYS-1:0]     hit;
    logic                victim_valid;
    logic                victim_dirty;
    logic [TAG_BITS-1:0] victim_tag;
  } way_status_t;

endpackage

// File: rtl/beat_counter.sv
`timescale 1ns/10ps

module beat_counter
  import cache_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       clear,
  input  logic       step,
  output logic [1:0] count,
  output logic       last
);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      count <= 2'd0;
    end else if (step) begin
      count <= count + 2'd1;
    end
  end

  // Final beat of the line
  assign last = (count == 2'(BEATS - 1));

endmodule

// File: rtl/plru.sv
`timescale 1ns/10ps

module plru
  import cache_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [SET_BITS-1:0] set,
  input  logic                update,
  input  logic [WAYS-1:0]     hit_way,
  output logic [WAYS-1:0]     victim
);

  // Bit 0 picks the half, bit 1 the way in 0/1, bit 2 the way in 2/3
  logic [2:0] tree [SETS];
  logic [2:0] cur;
  logic [1:0] victim_idx;

  assign cur        = tree[set];
  assign victim_idx = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
  assign victim     = WAYS'(1) << victim_idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < SETS; s++) begin
        tree[s] <= 3'b000;
      end
    end else if (update) begin
      // Point away from the way just used
      if (hit_way[0] || hit_way[1]) begin
        tree[set][0] <= 1'b1;
        tree[set][1] <= hit_way[0];
      end else if (hit_way[2] || hit_way[3]) begin
        tree[set][0] <= 1'b0;
        tree[set][2] <= hit_way[2];
      end
    end
  end

endmodule

// File: dcache/dcache_arrays.sv
`timescale 1ns/10ps

module dcache_arrays
  import cache_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst,
  input  logic [SET_BITS-1:0]            set,
  input  logic [WAYS-1:0]                way_we,
  input  logic [LINE_BITS/8-1:0]         byte_en,
  input  logic [LINE_BITS-1:0]           wdata,
  input  logic [TAG_BITS-1:0]            wtag,
  input  logic                           wdirty,
  input  logic                           wvalid,
  output logic [WAYS-1:0][TAG_BITS-1:0]  tags,
  output logic [WAYS-1:0]                dirty,
  output logic [WAYS-1:0]                valid,
  output logic [WAYS-1:0][LINE_BITS-1:0] data
);

  logic [TAG_BITS-1:0]  tag_mem   [WAYS][SETS];
  logic [LINE_BITS-1:0] data_mem  [WAYS][SETS];
  logic                 dirty_mem [WAYS][SETS];
  logic                 valid_mem [WAYS][SETS];

  // Line state bits
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
          valid_mem[w][s] <= 1'b0;
          dirty_mem[w][s] <= 1'b0;
        end
      end
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (way_we[w]) begin
          valid_mem[w][set] <= wvalid;
          dirty_mem[w][set] <= wdirty;
        end
      end
    end
  end

  // Tags and byte-masked line data
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (way_we[w]) begin
        tag_mem[w][set] <= wtag;
        for (int b = 0; b < LINE_BITS/8; b++) begin
          if (byte_en[b]) begin
            data_mem[w][set][b*8 +: 8] <= wdata[b*8 +: 8];
          end
        end
      end
    end
  end

  always_comb begin
    for (int w = 0; w < WAYS; w++) begin
      tags[w]  = tag_mem[w][set];
      dirty[w] = dirty_mem[w][set];
      valid[w] = valid_mem[w][set];
      data[w]  = data_mem[w][set];
    end
  end

endmodule

// File: dcache/dfp_burst.sv
`timescale 1ns/10ps

module dfp_burst
  import cache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  burst_op_e            op,
  input  logic [31:0]          line_addr,
  input  logic [LINE_BITS-1:0] wline,
  output logic [LINE_BITS-1:0] rline,
  output logic                 done,
  output logic                 dfp_req,
  output dfp_beat_t            dfp_beat,
  input  logic [BEAT_BITS-1:0] dfp_rdata,
  input  logic                 dfp_ack
);

  // Waiting for ack to fall after a beat
  logic        drain;
  burst_op_e   op_q;
  logic [31:0] base_q;
  logic [1:0]  count;
  logic        last;
  logic        step;

  assign step = drain && !dfp_ack;
  assign done = step && last;

  beat_counter u_beat_counter (
    .clk   (clk),
    .rst   (rst),
    .clear (start),
    .step  (step),
    .count (count),
    .last  (last)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      dfp_req <= 1'b0;
      drain   <= 1'b0;
    end else if (start) begin
      dfp_req <= 1'b1;
      drain   <= 1'b0;
    end else if (dfp_req && dfp_ack) begin
      dfp_req <= 1'b0;
      drain   <= 1'b1;
    end else if (step) begin
      drain   <= 1'b0;
      dfp_req <= !last;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q   <= op;
      base_q <= line_addr;
    end
    // Beats arrive lowest first and shift down toward bit 0
    if (dfp_req && dfp_ack && op_q == BURST_READ) begin
      rline <= {dfp_rdata, rline[LINE_BITS-1:BEAT_BITS]};
    end
  end

  always_comb begin
    dfp_beat.addr  = {base_q[31:OFFSET_BITS], count, 3'b000};
    dfp_beat.write = (op_q == BURST_WRITE);
    dfp_beat.wdata = wline[{count, 6'b000000} +: BEAT_BITS];
  end

endmodule

// File: dcache/dcache_control.sv
`timescale 1ns/10ps

module dcache_control
  import cache_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        ufp_req,
  input  logic        ufp_write,
  input  way_status_t status,
  input  logic        burst_done,
  input  logic        inval_req,
  output logic        capture,
  output logic        ufp_resp,
  output logic        burst_start,
  output burst_op_e   burst_op,
  output logic        write_store,
  output logic        write_refill,
  output logic        clear_valid,
  output logic        inval_sel,
  output logic        inval_resp,
  output logic        plru_update
);

  dcache_state_e state;
  dcache_state_e state_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      inval_resp <= 1'b0;
    end else begin
      state <= state_next;
      // Rises after one read cycle, falls once the requester lets go
      if (state == INVAL) begin
        if (!inval_resp) begin
          inval_resp <= 1'b1;
        end else if (!inval_req) begin
          inval_resp <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    state_next   = state;
    capture      = 1'b0;
    ufp_resp     = 1'b0;
    burst_start  = 1'b0;
    burst_op     = BURST_READ;
    write_store  = 1'b0;
    write_refill = 1'b0;
    clear_valid  = 1'b0;
    inval_sel    = 1'b0;
    plru_update  = 1'b0;

    case (state)
      IDLE: begin
        capture = 1'b1;
        // Back-invalidate wins over the CPU
        if (inval_req) begin
          state_next = INVAL;
        end else if (ufp_req) begin
          state_next = LOOKUP;
        end
      end

      LOOKUP: begin
        if (|status.hit) begin
          ufp_resp    = 1'b1;
          plru_update = 1'b1;
          write_store = ufp_write;
          state_next  = IDLE;
        end else if (status.victim_valid && status.victim_dirty) begin
          burst_start = 1'b1;
          burst_op    = BURST_WRITE;
          state_next  = WRITEBACK;
        end else begin
          burst_start = 1'b1;
          state_next  = REFILL;
        end
      end

      WRITEBACK: begin
        if (burst_done) begin
          burst_start = 1'b1;
          state_next  = REFILL;
        end
      end

      REFILL: begin
        if (burst_done) begin
          state_next = INSTALL;
        end
      end

      INSTALL: begin
        write_refill = 1'b1;
        state_next   = LOOKUP;
      end

      INVAL: begin
        inval_sel = 1'b1;
        if (inval_resp && !inval_req) begin
          clear_valid = |status.hit;
          state_next  = IDLE;
        end
      end

      default: state_next = IDLE;
    endcase
  end

endmodule

// File: dcache/dcache.sv
`timescale 1ns/10ps

module dcache
  import cache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          ufp_addr,
  input  logic [3:0]           ufp_rmask,
  input  logic [3:0]           ufp_wmask,
  input  logic [31:0]          ufp_wdata,
  output logic [31:0]          ufp_rdata,
  output logic                 ufp_resp,
  output logic                 dfp_req,
  output dfp_beat_t            dfp_beat,
  input  logic [BEAT_BITS-1:0] dfp_rdata,
  input  logic                 dfp_ack,
  input  logic                 inval_req,
  input  logic [31:0]          inval_addr,
  output logic                 inval_resp,
  output logic                 inval_hit,
  output logic                 inval_dirty,
  output logic [LINE_BITS-1:0] inval_data
);

  // Captured CPU request and invalidate address
  logic [31:0]                      addr_q;
  logic [31:0]                      wdata_q;
  logic [3:0]                       wmask_q;
  logic [31:0]                      inval_addr_q;

  logic [31:0]                      lookup_addr;
  logic [TAG_BITS-1:0]              tag;
  logic [SET_BITS-1:0]              set;
  logic [2:0]                       word_idx;

  // Controller strobes
  logic                             ufp_req;
  logic                             ufp_write;
  logic                             capture;
  logic                             burst_start;
  burst_op_e                        burst_op;
  logic                             burst_done;
  logic                             write_store;
  logic                             write_refill;
  logic                             clear_valid;
  logic                             inval_sel;
  logic                             plru_update;

  // Array ports
  logic [WAYS-1:0][TAG_BITS-1:0]    tags;
  logic [WAYS-1:0]                  dirty;
  logic [WAYS-1:0]                  valid;
  logic [WAYS-1:0][LINE_BITS-1:0]   data;
  logic [WAYS-1:0]                  way_we;
  logic [LINE_BITS/8-1:0]           byte_en;
  logic [LINE_BITS-1:0]             array_wdata;

  // Lookup results
  logic [WAYS-1:0]                  hit;
  logic [WAYS-1:0]                  victim;
  way_status_t                      status;
  logic [LINE_BITS-1:0]             hit_line;
  logic                             hit_dirty;
  logic [LINE_BITS-1:0]             victim_line;
  logic [TAG_BITS-1:0]              victim_tag;
  logic                             victim_valid;
  logic                             victim_dirty;

  logic [LINE_BITS-1:0]             store_line;
  logic [LINE_BITS/8-1:0]           store_be;
  logic [LINE_BITS-1:0]             rline;
  logic [31:0]                      line_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      wmask_q <= '0;
    end else if (capture) begin
      wmask_q <= ufp_wmask;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      addr_q  <= ufp_addr;
      wdata_q <= ufp_wdata;
    end
    // Held after the request drops so the valid clear hits the right set
    if (inval_req) begin
      inval_addr_q <= inval_addr;
    end
  end

  assign ufp_req     = (|ufp_rmask) || (|ufp_wmask);
  assign ufp_write   = |wmask_q;

  assign lookup_addr = inval_sel ? inval_addr_q : addr_q;
  assign tag         = lookup_addr[31 -: TAG_BITS];
  assign set         = lookup_addr[OFFSET_BITS +: SET_BITS];
  assign word_idx    = lookup_addr[OFFSET_BITS-1:2];

  // Tag compare and way selection
  always_comb begin
    hit_line     = '0;
    hit_dirty    = 1'b0;
    victim_line  = '0;
    victim_tag   = '0;
    victim_valid = 1'b0;
    victim_dirty = 1'b0;
    for (int w = 0; w < WAYS; w++) begin
      hit[w] = valid[w] && (tags[w] == tag);
      if (hit[w]) begin
        hit_line  = data[w];
        hit_dirty = dirty[w];
      end
      if (victim[w]) begin
        victim_line  = data[w];
        victim_tag   = tags[w];
        victim_valid = valid[w];
        victim_dirty = dirty[w];
      end
    end
    status.hit          = hit;
    status.victim_valid = victim_valid;
    status.victim_dirty = victim_dirty;
    status.victim_tag   = victim_tag;
  end

  assign ufp_rdata  = hit_line[{word_idx, 5'b00000} +: 32];

  // Store word replicated across the line, bytes picked by the enables
  assign store_line = {(LINE_BITS/32){wdata_q}};
  assign store_be   = {28'b0, wmask_q} << {word_idx, 2'b00};

  always_comb begin
    way_we  = '0;
    byte_en = '0;
    if (write_store) begin
      way_we  = hit;
      byte_en = store_be;
    end else if (write_refill) begin
      way_we  = victim;
      byte_en = '1;
    end else if (clear_valid) begin
      way_we  = hit;
    end
  end

  assign array_wdata = write_refill ? rline : store_line;

  assign inval_hit   = |hit;
  assign inval_dirty = hit_dirty;
  assign inval_data  = hit_line;

  // Victim goes back to its own address, refill comes from the request
  assign line_addr = (burst_op == BURST_WRITE) ?
                     {victim_tag, set, {OFFSET_BITS{1'b0}}} :
                     {addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};

  dcache_control u_control (
    .clk          (clk),
    .rst          (rst),
    .ufp_req      (ufp_req),
    .ufp_write    (ufp_write),
    .status       (status),
    .burst_done   (burst_done),
    .inval_req    (inval_req),
    .capture      (capture),
    .ufp_resp     (ufp_resp),
    .burst_start  (burst_start),
    .burst_op     (burst_op),
    .write_store  (write_store),
    .write_refill (write_refill),
    .clear_valid  (clear_valid),
    .inval_sel    (inval_sel),
    .inval_resp   (inval_resp),
    .plru_update  (plru_update)
  );

  dcache_arrays u_arrays (
    .clk     (clk),
    .rst     (rst),
    .set     (set),
    .way_we  (way_we),
    .byte_en (byte_en),
    .wdata   (array_wdata),
    .wtag    (tag),
    .wdirty  (write_store),
    .wvalid  (!clear_valid),
    .tags    (tags),
    .dirty   (dirty),
    .valid   (valid),
    .data    (data)
  );

  dfp_burst u_burst (
    .clk       (clk),
    .rst       (rst),
    .start     (burst_start),
    .op        (burst_op),
    .line_addr (line_addr),
    .wline     (victim_line),
    .rline     (rline),
    .done      (burst_done),
    .dfp_req   (dfp_req),
    .dfp_beat  (dfp_beat),
    .dfp_rdata (dfp_rdata),
    .dfp_ack   (dfp_ack)
  );

  plru u_plru (
    .clk     (clk),
    .rst     (rst),
    .set     (set),
    .update  (plru_update),
    .hit_way (hit),
    .victim  (victim)
  );

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic rst
);

  localparam int RESET_CYCLES = 10;

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: dv/dcache_checker.sv
`timescale 1ns/10ps

module dcache_checker
  import cache_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst,
  input  logic [31:0]          ufp_addr,
  input  logic [3:0]           ufp_rmask,
  input  logic [3:0]           ufp_wmask,
  input  logic [31:0]          ufp_wdata,
  input  logic [31:0]          ufp_rdata,
  input  logic                 ufp_resp,
  input  logic                 dfp_req,
  input  dfp_beat_t            dfp_beat,
  input  logic                 dfp_ack,
  input  logic                 inval_req,
  input  logic [31:0]          inval_addr,
  input  logic                 inval_resp,
  input  logic                 inval_hit,
  input  logic                 inval_dirty,
  input  logic [LINE_BITS-1:0] inval_data,
  output int                   error_count
);

  localparam logic [31:0] MEM_BASE = 32'h0004_0000;
  localparam logic [31:0] FILL     = 32'h5a5a_c3c3;

  // Reference word image updated by every store
  logic [31:0] ref_mem [1024];
  // Lines dropped by an invalidate and not yet read back from memory
  logic        refetch_due [128];
  // Lines holding stores that memory has not seen yet
  logic        dirty_line [128];
  int          checks;
  int          errors;
  int          req_len;
  logic        dfp_seen;
  logic        inval_seen;
  logic        last_valid;
  logic [31:0] last_addr;
  logic        prev_req;
  logic        prev_ack;
  logic        prev_inval_req;
  logic        prev_inval_resp;
  dfp_beat_t   prev_beat;
  logic        reset_edge;

  assign error_count = errors;

  initial begin
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = (MEM_BASE + 32'(i) * 4) ^ FILL;
    end
    for (int i = 0; i < 128; i++) begin
      refetch_due[i] = 1'b0;
      dirty_line[i]  = 1'b0;
    end
    checks          = 0;
    errors          = 0;
    req_len         = 0;
    dfp_seen        = 1'b0;
    inval_seen      = 1'b0;
    last_valid      = 1'b0;
    last_addr       = '0;
    prev_req        = 1'b0;
    prev_ack        = 1'b0;
    prev_inval_req  = 1'b0;
    prev_inval_resp = 1'b0;
    prev_beat       = '0;
    reset_edge      = 1'b0;
  end

  // Outputs are only defined once a clock edge has applied reset
  always @(posedge clk) begin
    if (rst) begin
      reset_edge <= 1'b1;
    end
  end

  function automatic logic [31:0] byte_bits(input logic [3:0] mask);
    logic [31:0] bits;
    for (int b = 0; b < 4; b++) begin
      bits[b*8 +: 8] = {8{mask[b]}};
    end
    return bits;
  endfunction

  task automatic check_handshakes;
    if (prev_req && dfp_req && dfp_beat !== prev_beat) begin
      errors++;
      $display("dfp_beat changed while dfp_req was high at %0t", $time);
    end
    if (prev_req && !dfp_req && !prev_ack) begin
      errors++;
      $display("dfp_req dropped before dfp_ack at %0t", $time);
    end
    if (prev_inval_resp && !inval_resp && prev_inval_req) begin
      errors++;
      $display("inval_resp dropped while inval_req was high at %0t", $time);
    end
  endtask

  task automatic check_memory_beat;
    logic [9:0]  idx;
    logic [63:0] expected;
    idx      = dfp_beat.addr[11:2];
    expected = {ref_mem[idx + 10'd1], ref_mem[idx]};
    if (dfp_beat.write) begin
      checks++;
      if (dfp_beat.wdata !== expected) begin
        errors++;
        $display("Fail t=%0t dfp_beat.wdata got %h expected %h",
                 $time, dfp_beat.wdata, expected);
      end
      // Written back lines leave the cache
      dirty_line[idx[9:3]] = 1'b0;
    end else begin
      refetch_due[idx[9:3]] = 1'b0;
    end
  endtask

  task automatic check_inval_reply;
    logic [LINE_BITS-1:0] expected;
    logic [6:0]           line;
    line = inval_addr[11:5];
    checks++;
    if (inval_dirty !== dirty_line[line]) begin
      errors++;
      $display("Fail t=%0t inval_dirty got %b expected %b",
               $time, inval_dirty, dirty_line[line]);
    end
    // A line with unwritten stores is still in the cache
    if (dirty_line[line] && inval_hit !== 1'b1) begin
      errors++;
      $display("Fail t=%0t inval_hit got %b expected %b", $time, inval_hit, 1'b1);
    end
    if (inval_hit) begin
      for (int w = 0; w < 8; w++) begin
        expected[w*32 +: 32] = ref_mem[{line, 3'(w)}];
      end
      checks++;
      if (inval_data !== expected) begin
        errors++;
        $display("Fail t=%0t inval_data got %h expected %h", $time, inval_data, expected);
      end
    end
    dirty_line[line]  = 1'b0;
    refetch_due[line] = 1'b1;
  endtask

  task automatic check_cpu_response;
    logic [9:0]  idx;
    logic [31:0] bits;
    idx  = ufp_addr[11:2];
    bits = byte_bits(ufp_rmask | ufp_wmask);
    // Same address again must hit without touching memory
    if (last_valid && ufp_addr == last_addr && !inval_seen) begin
      checks++;
      if (req_len != 2 || dfp_seen) begin
        errors++;
        $display("Repeated access to %h at %0t took %0d cycles, memory used %0b",
                 ufp_addr, $time, req_len, dfp_seen);
      end
    end
    if (refetch_due[idx[9:3]]) begin
      errors++;
      $display("Access to %h at %0t after an invalidate read nothing from memory",
               ufp_addr, $time);
      refetch_due[idx[9:3]] = 1'b0;
    end
    if (|ufp_rmask) begin
      checks++;
      if ((ufp_rdata & bits) !== (ref_mem[idx] & bits)) begin
        errors++;
        $display("Fail t=%0t ufp_rdata got %h expected %h",
                 $time, ufp_rdata & bits, ref_mem[idx] & bits);
      end
    end else begin
      ref_mem[idx]         = (ref_mem[idx] & ~bits) | (ufp_wdata & bits);
      dirty_line[idx[9:3]] = 1'b1;
    end
    last_addr  = ufp_addr;
    last_valid = 1'b1;
    req_len    = 0;
    dfp_seen   = 1'b0;
    inval_seen = 1'b0;
  endtask

  // Sample on the falling edge away from the driving edge
  always @(negedge clk) begin
    if (rst) begin
      if (reset_edge &&
          (ufp_resp !== 1'b0 || dfp_req !== 1'b0 || inval_resp !== 1'b0)) begin
        errors++;
        $display("Response or request outputs not low during reset at %0t", $time);
      end
    end else begin
      check_handshakes();
      if (dfp_req && dfp_ack) begin
        check_memory_beat();
      end
      if (inval_resp && !prev_inval_resp) begin
        check_inval_reply();
      end
      if ((|ufp_rmask) || (|ufp_wmask)) begin
        req_len++;
      end
      if (dfp_req) begin
        dfp_seen = 1'b1;
      end
      if (inval_req) begin
        inval_seen = 1'b1;
      end
      if (ufp_resp) begin
        check_cpu_response();
      end
    end
    prev_req        = dfp_req;
    prev_ack        = dfp_ack;
    prev_beat       = dfp_beat;
    prev_inval_req  = inval_req;
    prev_inval_resp = inval_resp;
  end

  task print_summary;
    $display("Checker: %0d checks, %0d errors", checks, errors);
  endtask

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/10ps

module dcache_tb
  import cache_pkg::*;
();

  localparam logic [31:0] SEED           = 32'h50fc;
  localparam logic [31:0] MEM_BASE       = 32'h0004_0000;
  localparam logic [31:0] FILL           = 32'h5a5a_c3c3;
  localparam int          NUM_OPS        = 400;
  localparam int          CYCLES_PER_OP  = 80;
  localparam int          RESET_CYCLES   = 10;
  localparam int          TIMEOUT_CYCLES = NUM_OPS * CYCLES_PER_OP + RESET_CYCLES;

  logic                 clk;
  logic                 rst;
  logic [31:0]          ufp_addr;
  logic [3:0]           ufp_rmask;
  logic [3:0]           ufp_wmask;
  logic [31:0]          ufp_wdata;
  logic [31:0]          ufp_rdata;
  logic                 ufp_resp;
  logic                 dfp_req;
  dfp_beat_t            dfp_beat;
  logic [BEAT_BITS-1:0] dfp_rdata;
  logic                 dfp_ack;
  logic                 inval_req;
  logic [31:0]          inval_addr;
  logic                 inval_resp;
  logic                 inval_hit;
  logic                 inval_dirty;
  logic [LINE_BITS-1:0] inval_data;
  int                   error_count;

  // Backing memory with one word per entry
  logic [31:0]          mem [1024];
  integer               cpu_seed   = SEED;
  integer               mem_seed   = SEED ^ 32'h1;
  integer               inval_seed = SEED ^ 32'h2;
  logic                 ops_done;
  int                   cycles     = 0;

  // Dirty line from an invalidate that the memory process writes back
  logic [LINE_BITS-1:0] wb_line;
  logic [6:0]           wb_line_idx;
  int                   wb_posted  = 0;
  int                   wb_applied = 0;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  dcache dut (
    .clk         (clk),
    .rst         (rst),
    .ufp_addr    (ufp_addr),
    .ufp_rmask   (ufp_rmask),
    .ufp_wmask   (ufp_wmask),
    .ufp_wdata   (ufp_wdata),
    .ufp_rdata   (ufp_rdata),
    .ufp_resp    (ufp_resp),
    .dfp_req     (dfp_req),
    .dfp_beat    (dfp_beat),
    .dfp_rdata   (dfp_rdata),
    .dfp_ack     (dfp_ack),
    .inval_req   (inval_req),
    .inval_addr  (inval_addr),
    .inval_resp  (inval_resp),
    .inval_hit   (inval_hit),
    .inval_dirty (inval_dirty),
    .inval_data  (inval_data)
  );

  dcache_checker chk (
    .clk         (clk),
    .rst         (rst),
    .ufp_addr    (ufp_addr),
    .ufp_rmask   (ufp_rmask),
    .ufp_wmask   (ufp_wmask),
    .ufp_wdata   (ufp_wdata),
    .ufp_rdata   (ufp_rdata),
    .ufp_resp    (ufp_resp),
    .dfp_req     (dfp_req),
    .dfp_beat    (dfp_beat),
    .dfp_ack     (dfp_ack),
    .inval_req   (inval_req),
    .inval_addr  (inval_addr),
    .inval_resp  (inval_resp),
    .inval_hit   (inval_hit),
    .inval_dirty (inval_dirty),
    .inval_data  (inval_data),
    .error_count (error_count)
  );

  // Eight tags over four sets so that every set sees eviction
  function automatic logic [31:0] addr_from_bits(input logic [31:0] r);
    return MEM_BASE | {20'b0, r[7:5], 2'b00, r[4:3], r[2:0], 2'b00};
  endfunction

  task automatic serve_beat;
    dfp_beat_t  beat;
    logic [9:0] idx;
    int         delay;
    beat  = dfp_beat;
    idx   = beat.addr[11:2];
    delay = $unsigned($random(mem_seed)) % 4;
    repeat (delay) @(posedge clk);
    @(posedge clk);
    if (beat.write) begin
      mem[idx]         = beat.wdata[31:0];
      mem[idx + 10'd1] = beat.wdata[63:32];
    end else begin
      dfp_rdata <= {mem[idx + 10'd1], mem[idx]};
    end
    dfp_ack <= 1'b1;
    do @(negedge clk); while (dfp_req);
    @(posedge clk);
    dfp_ack <= 1'b0;
  endtask

  // Memory model
  initial begin
    dfp_ack   = 1'b0;
    dfp_rdata = '0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (MEM_BASE + 32'(i) * 4) ^ FILL;
    end
    forever begin
      @(negedge clk);
      if (wb_applied != wb_posted) begin
        for (int w = 0; w < 8; w++) begin
          mem[{wb_line_idx, 3'(w)}] = wb_line[w*32 +: 32];
        end
        wb_applied = wb_posted;
      end
      if (!rst && dfp_req && !dfp_ack) begin
        serve_beat();
      end
    end
  end

  task automatic cpu_access(input logic [31:0] addr, input logic write,
                            input logic [3:0] mask, input logic [31:0] wdata);
    @(posedge clk);
    ufp_addr  <= addr;
    ufp_wdata <= wdata;
    ufp_rmask <= write ? 4'h0 : mask;
    ufp_wmask <= write ? mask : 4'h0;
    do @(negedge clk); while (!ufp_resp);
  endtask

  task automatic run_cpu_ops;
    logic [31:0] r;
    logic [31:0] addr;
    logic [31:0] last;
    logic [3:0]  mask;
    last = addr_from_bits(32'h0);
    for (int i = 0; i < NUM_OPS; i++) begin
      r    = $random(cpu_seed);
      // One in four repeats the address just answered
      addr = (i > 0 && r[9:8] == 2'b00) ? last : addr_from_bits(r);
      mask = r[13:10];
      if (mask == 4'h0) begin
        mask = 4'hf;
      end
      cpu_access(addr, r[14], mask, $random(cpu_seed));
      last = addr;
      if (r[15]) begin
        @(posedge clk);
        ufp_rmask <= 4'h0;
        ufp_wmask <= 4'h0;
        repeat (r[17:16]) @(posedge clk);
      end
    end
    @(posedge clk);
    ufp_rmask <= 4'h0;
    ufp_wmask <= 4'h0;
    ops_done = 1'b1;
  endtask

  task automatic back_invalidate(input logic [31:0] addr);
    @(posedge clk);
    inval_req  <= 1'b1;
    inval_addr <= addr;
    do @(negedge clk); while (!inval_resp);
    if (inval_dirty) begin
      wb_line     = inval_data;
      wb_line_idx = addr[11:5];
      wb_posted++;
    end
    @(posedge clk);
    inval_req <= 1'b0;
    do @(negedge clk); while (inval_resp);
  endtask

  task automatic run_invalidates;
    logic [31:0] r;
    while (!ops_done) begin
      r = $random(inval_seed);
      repeat (20 + r[5:0]) @(posedge clk);
      if (!ops_done) begin
        back_invalidate(addr_from_bits(r >> 8));
      end
    end
  endtask

  initial begin
    ufp_addr   = '0;
    ufp_rmask  = '0;
    ufp_wmask  = '0;
    ufp_wdata  = '0;
    inval_req  = 1'b0;
    inval_addr = '0;
    ops_done   = 1'b0;
    wait (rst === 1'b0);
    fork
      run_cpu_ops();
      run_invalidates();
    join
    repeat (4) @(posedge clk);
    chk.print_summary();
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", TIMEOUT_CYCLES);
      chk.print_summary();
      $display("Checks failed");
      $finish;
    end
  end

endmodule

// File: dcache.f
common/cache_pkg.sv
rtl/beat_counter.sv
rtl/plru.sv
dcache/dcache_arrays.sv
dcache/dfp_burst.sv
dcache/dcache_control.sv
dcache/dcache.sv
dv/tb_clock.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - files:
      - common/cache_pkg.sv
      - rtl/beat_counter.sv
      - rtl/plru.sv
      - dcache/dcache_arrays.sv
      - dcache/dfp_burst.sv
      - dcache/dcache_control.sv
      - dcache/dcache.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/dcache_checker.sv
      - dv/dcache_tb.sv
